//--- Bender.yml
package:
  name: fa_cache

sources:
  - source/fa_cache_pkg.sv
  - source/fa_tag_lookup.sv
  - source/fa_cache_controller.sv
  - source/fa_block_memory.sv
  - source/fa_perf_counters.sv
  - source/fa_cache_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/fa_cache_assert.sv
      - dv/tb_fa_cache.sv

//--- dv/fa_cache_assert.sv
`timescale 1ns/1ns

module fa_cache_assert (
	input logic                   clock_bus_i,
	input logic                   resetn_i,
	input logic                   accept_i,
	input logic                   done_i,
	input logic                   read_i,
	input logic                   write_i,
	input logic                   ready_req_i,
	input logic                   ready_read_i,
	input logic                   ready_write_i,
	input fa_cache_pkg::mem_cmd_t mem_cmd_i
);

	int unsigned fail_count = 0;     // read by the testbench at the end of the run

	// strobes only while the memory side is ready
	// ------------------------------
	a_read_ready: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		read_i |-> ready_read_i)
		else begin
			fail_count++;
			$error("read_o high while ready_read_i is low");
		end

	a_write_ready: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		write_i |-> ready_write_i)
		else begin
			fail_count++;
			$error("write_o high while ready_write_i is low");
		end

	// second done in a row needs a fresh request loaded in between
	a_done_once: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		done_i && $past(done_i) |-> $past(accept_i, 2))
		else begin
			fail_count++;
			$error("done_o held for two cycles on one request");
		end

	// command level and address hold until the memory takes it
	a_cmd_hold: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		mem_cmd_i.req && !ready_req_i |=> mem_cmd_i.req && $stable(mem_cmd_i))
		else begin
			fail_count++;
			$error("memory command dropped or changed before ready_req_i");
		end

endmodule

bind fa_cache_controller fa_cache_assert assert0 (
	.clock_bus_i   (clock_bus_i),
	.resetn_i      (resetn_i),
	.accept_i      (accept_o),
	.done_i        (done_o),
	.read_i        (read_o),
	.write_i       (write_o),
	.ready_req_i   (ready_req_i),
	.ready_read_i  (ready_read_i),
	.ready_write_i (ready_write_i),
	.mem_cmd_i     (mem_cmd_o)
);

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
)(
	output logic clock_bus_o,
	output logic resetn_o
);

	initial begin
		clock_bus_o = 1'b0;
		forever #(PERIOD_NS / 2) clock_bus_o = ~clock_bus_o;
	end

	// release lines up with the input drive point, 1 ns after the edge
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_bus_o);
		#1 resetn_o = 1'b1;
	end

endmodule

//--- dv/tb_fa_cache.sv
`timescale 1ns/1ns

module tb_fa_cache;

	localparam int CAPACITY        = 4;      // small cache, evictions come quickly
	localparam int NUM_REQUESTS    = 51;     // directed plus random requests
	localparam int WATCHDOG_CYCLES = 200 * NUM_REQUESTS + 1000;
	localparam int TW              = fa_cache_pkg::BW_TAG;

	// DUT nets
	// ------------------------------
	logic                      clock_bus;
	logic                      resetn;
	logic                      req;
	logic                      rw;
	logic [15:0]               add;
	logic [31:0]               core_wdata;
	fa_cache_pkg::metric_sel_e metric_sel;
	logic                      ready;
	logic                      done;
	logic                      hit;
	logic [31:0]               core_rdata;
	logic [31:0]               count;
	logic                      ready_req;
	logic                      ready_read;
	logic                      ready_write;
	logic [31:0]               mem_rdata;     // memory to cache
	fa_cache_pkg::mem_cmd_t    mem_cmd;
	logic                      mem_read;
	logic                      mem_write;
	logic [31:0]               mem_wdata;     // cache to memory

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) clk0 (
		.clock_bus_o (clock_bus),
		.resetn_o    (resetn)
	);

	fa_cache_top #(.CACHE_BLOCK_CAPACITY(CAPACITY)) dut0 (
		.clock_bus_i   (clock_bus),
		.resetn_i      (resetn),
		.req_i         (req),
		.rw_i          (rw),
		.add_i         (add),
		.data_i        (core_wdata),
		.metric_sel_i  (metric_sel),
		.ready_o       (ready),
		.done_o        (done),
		.hit_o         (hit),
		.data_o        (core_rdata),
		.count_o       (count),
		.ready_req_i   (ready_req),
		.ready_read_i  (ready_read),
		.ready_write_i (ready_write),
		.mem_data_i    (mem_rdata),
		.mem_cmd_o     (mem_cmd),
		.read_o        (mem_read),
		.write_o       (mem_write),
		.mem_data_o    (mem_wdata)
	);

	// reference model and memory model state
	// ------------------------------
	logic [TW-1:0]          resident [$];              // oldest block first
	bit                     dirty_tag [logic [TW-1:0]];
	logic [31:0]            arch [logic [15:0]];       // last value the core wrote
	logic [31:0]            backing [logic [15:0]];    // words written back to memory
	fa_cache_pkg::mem_cmd_t cmd_log [$];               // completed memory commands
	int                     tally_req, tally_hit, tally_miss, tally_wb;
	int                     rd_pulses, wr_pulses, wb_cmds;

	task automatic abort_run(input string why);
		if (why != "") $display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			abort_run("");
		end
	endtask

	// fill rule for a word never written back
	function automatic logic [31:0] pattern_word(input logic [15:0] addr);
		return {16'h0000, addr} ^ 32'hA5A50000;
	endfunction

	function automatic logic [31:0] arch_word(input logic [15:0] addr);
		if (arch.exists(addr)) return arch[addr];
		return pattern_word(addr);
	endfunction

	function automatic logic [31:0] backing_word(input logic [15:0] addr);
		if (backing.exists(addr)) return backing[addr];
		return pattern_word(addr);
	endfunction

	// FIFO replacement, write-allocate, write-back
	task automatic predict(input logic write, input logic [15:0] addr, input logic [31:0] data,
	                       output logic exp_hit, output logic exp_wb, output logic [TW-1:0] victim);
		logic [TW-1:0] tag;
		tag     = addr[15:2];
		exp_hit = 1'b0;
		exp_wb  = 1'b0;
		victim  = '0;
		foreach (resident[i]) if (resident[i] == tag) exp_hit = 1'b1;
		tally_req++;
		if (exp_hit) begin
			tally_hit++;
		end else begin
			tally_miss++;
			if (resident.size() == CAPACITY) begin
				victim = resident.pop_front();      // oldest fill goes first
				exp_wb = dirty_tag.exists(victim) && dirty_tag[victim];
				if (exp_wb) tally_wb++;
				dirty_tag[victim] = 1'b0;
			end
			resident.push_back(tag);
			dirty_tag[tag] = 1'b0;
		end
		if (write) begin
			dirty_tag[tag] = 1'b1;
			arch[addr]     = data;
		end
	endtask

	// answers commands, streams fill words, takes write-back words
	task automatic mem_model();
		fa_cache_pkg::mem_cmd_t s_cmd;
		logic                   s_ready_req, s_read, s_write;
		logic [31:0]            s_wdata;
		logic [TW-1:0]          wb_block, fetch_block;
		logic [1:0]             wb_cnt, fetch_cnt;
		int                     delay;
		wb_block    = '0;
		fetch_block = '0;
		wb_cnt      = '0;
		fetch_cnt   = '0;
		delay       = 0;
		forever begin
			@(negedge clock_bus);              // outputs settled mid cycle
			s_cmd       = mem_cmd;
			s_ready_req = ready_req;
			s_read      = mem_read;
			s_write     = mem_write;
			s_wdata     = mem_wdata;
			@(posedge clock_bus);
			#1;
			if (s_cmd.req && s_ready_req) begin
				cmd_log.push_back(s_cmd);
				if (s_cmd.rw) begin
					wb_block = s_cmd.block_addr;
					wb_cnt   = '0;
					wb_cmds++;
				end else begin
					fetch_block = s_cmd.block_addr;
					fetch_cnt   = '0;
				end
			end
			if (s_read) begin
				rd_pulses++;
				fetch_cnt++;
			end
			if (s_write) begin
				check_value("mem_data_o", s_wdata, arch_word({wb_block, wb_cnt}));
				backing[{wb_block, wb_cnt}] = s_wdata;
				wr_pulses++;
				wb_cnt++;
			end
			if (mem_cmd.req) begin
				ready_req = (delay == 0);
				if (delay != 0) delay--;
			end else begin
				ready_req = 1'b0;
				delay     = $urandom % 4;      // 0 to 3 cycle answer
			end
			ready_read  = ($urandom % 4) != 0;
			ready_write = ($urandom % 4) != 0;
			mem_rdata   = backing_word({fetch_block, fetch_cnt});
		end
	endtask

	// core side helpers
	// ------------------------------
	task automatic drive_core(input logic valid, input logic write, input logic [15:0] addr,
	                          input logic [31:0] data);
		req        = valid;
		rw         = write;
		add        = addr;
		core_wdata = data;
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		@(posedge clock_bus);
		#1;
		while (!ready) begin
			waited++;
			if (waited > 200) abort_run("ready_o stayed low, the cache took no new request");
			@(posedge clock_bus);
			#1;
		end
	endtask

	task automatic do_request(input logic write, input logic [15:0] addr,
	                          input logic [31:0] data, output int latency);
		logic          exp_hit, exp_wb;
		logic [TW-1:0] victim;
		logic [31:0]   exp_data;
		exp_data = arch_word(addr);              // value before this request
		predict(write, addr, data, exp_hit, exp_wb, victim);
		cmd_log.delete();
		rd_pulses = 0;
		wr_pulses = 0;
		wait_ready();
		drive_core(1'b1, write, addr, data);
		latency = 0;
		do begin
			@(posedge clock_bus);
			#1;
			drive_core(1'b0, 1'b0, '0, '0);      // single cycle pulse
			latency++;
			if (latency > 200) abort_run("done_o never came for a core request");
		end while (!done);
		check_value("hit_o", hit, exp_hit);
		if (!write) check_value("data_o", core_rdata, exp_data);
		check_value("memory command count", cmd_log.size(), exp_hit ? 0 : (exp_wb ? 2 : 1));
		if (exp_wb) begin
			check_value("write-back mem_cmd_o.rw", cmd_log[0].rw, 1'b1);
			check_value("write-back block address", cmd_log[0].block_addr, victim);
		end
		if (!exp_hit) begin
			check_value("fetch mem_cmd_o.rw", cmd_log[cmd_log.size() - 1].rw, 1'b0);
			check_value("fetch block address", cmd_log[cmd_log.size() - 1].block_addr, addr[15:2]);
		end
		check_value("read_o pulses", rd_pulses, exp_hit ? 0 : 4);
		check_value("write_o pulses", wr_pulses, exp_wb ? 4 : 0);
	endtask

	task automatic read_metric(input fa_cache_pkg::metric_sel_e sel, output logic [31:0] value);
		@(posedge clock_bus);
		#1;
		metric_sel = sel;
		@(negedge clock_bus);
		value = count;
	endtask

	task automatic check_metrics(input int exp_req, input int exp_hit, input int exp_miss,
	                             input int exp_wb);
		logic [31:0] value;
		repeat (3) @(posedge clock_bus);         // flags reach the counters an edge late
		read_metric(fa_cache_pkg::METRIC_REQUESTS, value);
		check_value("count_o requests", value, exp_req);
		read_metric(fa_cache_pkg::METRIC_HITS, value);
		check_value("count_o hits", value, exp_hit);
		read_metric(fa_cache_pkg::METRIC_MISSES, value);
		check_value("count_o misses", value, exp_miss);
		read_metric(fa_cache_pkg::METRIC_WRITEBACKS, value);
		check_value("count_o writebacks", value, exp_wb);
	endtask

	// directed tests
	// ------------------------------
	task automatic check_reset_state();
		@(posedge clock_bus);
		#1;
		check_value("ready_o", ready, 1'b1);
		check_value("done_o", done, 1'b0);
		check_value("mem_cmd_o.req", mem_cmd.req, 1'b0);
		check_value("read_o", mem_read, 1'b0);
		check_value("write_o", mem_write, 1'b0);
		check_metrics(0, 0, 0, 0);
	endtask

	task automatic cold_read_miss();
		int lat;
		do_request(1'b0, 16'h0124, '0, lat);     // block 0x49, cache empty
	endtask

	task automatic read_hits();
		logic          hit_a, hit_b, wb;
		logic [TW-1:0] victim;
		int            lat;
		do_request(1'b0, 16'h0126, '0, lat);
		check_value("hit latency in edges", lat, 2);
		predict(1'b0, 16'h0124, '0, hit_a, wb, victim);
		predict(1'b0, 16'h0127, '0, hit_b, wb, victim);
		cmd_log.delete();
		wait_ready();
		drive_core(1'b1, 1'b0, 16'h0124, '0);
		@(posedge clock_bus);
		#1;
		check_value("ready_o during hit", ready, 1'b1);
		drive_core(1'b1, 1'b0, 16'h0127, '0);    // next cycle, pipelined
		@(posedge clock_bus);
		#1;
		drive_core(1'b0, 1'b0, '0, '0);
		check_value("done_o first", done, 1'b1);
		check_value("hit_o first", hit, hit_a);
		check_value("data_o first", core_rdata, arch_word(16'h0124));
		@(posedge clock_bus);
		#1;
		check_value("done_o second", done, 1'b1);
		check_value("hit_o second", hit, hit_b);
		check_value("data_o second", core_rdata, arch_word(16'h0127));
		check_value("memory commands on hits", cmd_log.size(), 0);
	endtask

	task automatic write_then_read();
		int lat;
		do_request(1'b1, 16'h0125, 32'hDEADBEEF, lat);   // dirties block 0x49
		do_request(1'b0, 16'h0125, '0, lat);
	endtask

	task automatic fifo_eviction();
		int lat;
		int wb_before;
		wb_before = wb_cmds;
		for (int i = 0; i < 4; i++) begin
			do_request(1'b0, {TW'(32'h10 + i), 2'd0}, '0, lat);   // last fill evicts 0x49
		end
		check_value("write-back commands during fills", wb_cmds - wb_before, 1);
		do_request(1'b0, 16'h0125, '0, lat);    // comes back from memory
		check_value("data_o after refetch", core_rdata, 32'hDEADBEEF);
	endtask

	task automatic random_mix_counters();
		logic [TW-1:0] tag;
		logic [15:0]   addr;
		int            lat;
		for (int n = 0; n < 40; n++) begin
			tag  = TW'(32'h20 + ($urandom % 6));       // six blocks over four ways
			addr = {tag, 2'($urandom % 4)};
			do_request(1'($urandom % 2), addr, $urandom, lat);
		end
		check_metrics(tally_req, tally_hit, tally_miss, tally_wb);
	endtask

	initial begin
		drive_core(1'b0, 1'b0, '0, '0);
		metric_sel  = fa_cache_pkg::METRIC_REQUESTS;
		ready_req   = 1'b0;
		ready_read  = 1'b0;
		ready_write = 1'b0;
		mem_rdata   = '0;
		tally_req   = 0;
		tally_hit   = 0;
		tally_miss  = 0;
		tally_wb    = 0;
		rd_pulses   = 0;
		wr_pulses   = 0;
		wb_cmds     = 0;
		void'($urandom(89));
		fork
			mem_model();
			begin
				repeat (WATCHDOG_CYCLES) @(posedge clock_bus);
				abort_run("watchdog expired, the tests took too long");
			end
		join_none
		@(posedge resetn);
		check_reset_state();
		cold_read_miss();
		read_hits();
		write_then_read();
		fifo_eviction();
		random_mix_counters();
		if (dut0.ctrl0.assert0.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run("a protocol assertion failed during the run");
		end
	end

endmodule

//--- project.f
source/fa_cache_pkg.sv
source/fa_tag_lookup.sv
source/fa_cache_controller.sv
source/fa_block_memory.sv
source/fa_perf_counters.sv
source/fa_cache_top.sv
dv/tb_clock_gen.sv
dv/fa_cache_assert.sv
dv/tb_fa_cache.sv

//--- source/fa_block_memory.sv
`timescale 1ns/1ns

module fa_block_memory #(
	parameter int CACHE_BLOCK_CAPACITY = 8
)(
	input  logic                                    clock_bus_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)+fa_cache_pkg::BW_BLOCK-1:0] addr_i,  // [way|word]
	input  logic                                    wren_i,
	input  logic [fa_cache_pkg::BW_DATA-1:0]        wdata_i,
	output logic [fa_cache_pkg::BW_DATA-1:0]        q_o
);

	// every way holds one block of 4 words
	localparam int DEPTH = CACHE_BLOCK_CAPACITY << fa_cache_pkg::BW_BLOCK;

	logic [fa_cache_pkg::BW_DATA-1:0] mem_q [DEPTH];

	// single port, read returns the old word on a write edge
	always_ff @(posedge clock_bus_i) begin
		if (wren_i) begin
			mem_q[addr_i] <= wdata_i;
		end
		q_o <= mem_q[addr_i];          // registered read, one edge latency
	end

endmodule

//--- source/fa_cache_controller.sv
`timescale 1ns/1ns

module fa_cache_controller #(
	parameter int CACHE_BLOCK_CAPACITY = 8
)(
	input  logic                                    clock_bus_i,
	input  logic                                    resetn_i,

	// lookup stage
	input  fa_cache_pkg::lookup_t                   lookup_i,
	input  logic                                    cam_hit_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_way_i,
	output logic                                    accept_o,
	output logic                                    cam_wren_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_way_wr_o,

	// block memory
	input  logic [fa_cache_pkg::BW_DATA-1:0]        mem_q_i,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)+fa_cache_pkg::BW_BLOCK-1:0] mem_addr_o,
	output logic                                    mem_wren_o,
	output logic [fa_cache_pkg::BW_DATA-1:0]        mem_wdata_o,

	// core and counters
	output logic                                    done_o,
	output logic                                    hit_o,
	output fa_cache_pkg::event_t                    events_o,

	// external memory
	input  logic                                    ready_req_i,
	input  logic                                    ready_read_i,
	input  logic                                    ready_write_i,
	input  logic [fa_cache_pkg::BW_DATA-1:0]        mem_data_i,
	output fa_cache_pkg::mem_cmd_t                  mem_cmd_o,
	output logic                                    read_o,
	output logic                                    write_o,
	output logic [fa_cache_pkg::BW_DATA-1:0]        mem_data_o
);

	localparam int BW_WAY = $clog2(CACHE_BLOCK_CAPACITY);

	typedef enum logic [2:0] {
		ST_IDLE,          // serve hits, detect misses
		ST_WB_CMD,        // write-back command pending
		ST_WB_WORDS,      // stream victim out
		ST_FETCH_CMD,     // fetch command pending
		ST_FETCH_WORDS,   // stream new block in
		ST_INSTALL        // tag into CAM, bump FIFO pointer
	} state_e;

	state_e                              state_q;
	logic [BW_WAY-1:0]                   fifo_ptr_q;   // next victim way
	logic [fa_cache_pkg::BW_BLOCK-1:0]   word_cnt_q;   // wraps to 0 after each block
	logic [CACHE_BLOCK_CAPACITY-1:0]     dirty_q;
	logic [fa_cache_pkg::BW_TAG-1:0]     vtag_q [CACHE_BLOCK_CAPACITY];  // tag per way for wb
	logic                                missed_q;     // held request already missed once
	logic                                done_q;
	logic                                hit_q;
	fa_cache_pkg::event_t                events_q;

	logic                                hit_accept;
	logic                                first_lookup;
	logic                                last_word;
	logic [fa_cache_pkg::BW_BLOCK-1:0]   wb_word;      // victim word to prefetch

	// handshake with lookup stage
	// ------------------------------
	assign hit_accept   = (state_q == ST_IDLE) && lookup_i.valid && cam_hit_i;
	assign accept_o     = (state_q == ST_IDLE) && (!lookup_i.valid || cam_hit_i);
	assign first_lookup = (state_q == ST_IDLE) && lookup_i.valid && !missed_q;
	assign cam_wren_o   = (state_q == ST_INSTALL);
	assign cam_way_wr_o = fifo_ptr_q;                  // fill always lands in the victim way

	// memory strobes only while the buffer is ready
	assign write_o    = (state_q == ST_WB_WORDS) && ready_write_i;
	assign read_o     = (state_q == ST_FETCH_WORDS) && ready_read_i;
	assign mem_data_o = mem_q_i;                       // victim word, read one cycle ahead
	assign last_word  = (word_cnt_q == '1);

	// command is a level decoded from state
	assign mem_cmd_o.req        = (state_q == ST_WB_CMD) || (state_q == ST_FETCH_CMD);
	assign mem_cmd_o.rw         = (state_q == ST_WB_CMD);
	assign mem_cmd_o.block_addr = (state_q == ST_WB_CMD) ? vtag_q[fifo_ptr_q]
	                                                     : lookup_i.req.tag;

	// step to the next victim word on a transfer so q is ready for it
	assign wb_word = write_o ? word_cnt_q + 1'b1 : word_cnt_q;

	// block memory port
	// ------------------------------
	always_comb begin
		mem_addr_o  = {fifo_ptr_q, word_cnt_q};        // also word 0 prefetch in ST_WB_CMD
		mem_wren_o  = 1'b0;
		mem_wdata_o = mem_data_i;
		case (state_q)
			ST_IDLE: begin
				mem_addr_o  = {cam_way_i, lookup_i.req.word};
				mem_wren_o  = hit_accept && lookup_i.req.rw;
				mem_wdata_o = lookup_i.req.wdata;
			end
			ST_WB_WORDS:    mem_addr_o = {fifo_ptr_q, wb_word};
			ST_FETCH_WORDS: mem_wren_o = read_o;    // fill word straight from the bus
			default:        ;
		endcase
	end

	// miss FSM
	// ------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			state_q    <= ST_IDLE;
			fifo_ptr_q <= '0;
			word_cnt_q <= '0;
			dirty_q    <= '0;
			missed_q   <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (hit_accept) begin
						missed_q <= 1'b0;
						if (lookup_i.req.rw) begin
							dirty_q[cam_way_i] <= 1'b1;   // write hit dirties the block
						end
					end else if (lookup_i.valid) begin
						missed_q <= 1'b1;
						state_q  <= dirty_q[fifo_ptr_q] ? ST_WB_CMD : ST_FETCH_CMD;
					end
				end
				ST_WB_CMD: begin
					if (ready_req_i) state_q <= ST_WB_WORDS;
				end
				ST_WB_WORDS: begin
					if (write_o) begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (last_word) state_q <= ST_FETCH_CMD;
					end
				end
				ST_FETCH_CMD: begin
					if (ready_req_i) state_q <= ST_FETCH_WORDS;
				end
				ST_FETCH_WORDS: begin
					if (read_o) begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (last_word) state_q <= ST_INSTALL;
					end
				end
				ST_INSTALL: begin
					dirty_q[fifo_ptr_q] <= 1'b0;
					fifo_ptr_q          <= fifo_ptr_q + 1'b1;   // round-robin replacement
					state_q             <= ST_IDLE;             // held request looks up again
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// tag copy for write-back addressing
	always_ff @(posedge clock_bus_i) begin
		if (state_q == ST_INSTALL) begin
			vtag_q[fifo_ptr_q] <= lookup_i.req.tag;
		end
	end

	// core response and event flags
	// ------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			done_q   <= 1'b0;
			hit_q    <= 1'b0;
			events_q <= '0;
		end else begin
			done_q             <= hit_accept;                  // q arrives in the same cycle
			hit_q              <= hit_accept && !missed_q;
			events_q.request   <= first_lookup;
			events_q.hit       <= first_lookup && cam_hit_i;
			events_q.miss      <= first_lookup && !cam_hit_i;
			events_q.writeback <= (state_q == ST_WB_CMD) && ready_req_i;  // once per victim
		end
	end

	assign done_o   = done_q;
	assign hit_o    = hit_q;
	assign events_o = events_q;

endmodule

//--- source/fa_cache_pkg.sv
package fa_cache_pkg;

	// address and data geometry
	// ------------------------------
	localparam int BW_WORD_ADDR = 16;                         // core word address
	localparam int BW_BLOCK     = 2;                          // word offset, 4 words per block
	localparam int BW_TAG       = BW_WORD_ADDR - BW_BLOCK;    // block address doubles as tag
	localparam int BW_DATA      = 32;

	// core request, packed by the top level
	typedef struct packed {
		logic                rw;      // 1: write, 0: read
		logic [BW_TAG-1:0]   tag;
		logic [BW_BLOCK-1:0] word;
		logic [BW_DATA-1:0]  wdata;   // only meaningful on writes
	} core_req_t;

	// request register of the lookup stage
	typedef struct packed {
		logic      valid;
		core_req_t req;
	} lookup_t;

	// block command towards external memory
	typedef struct packed {
		logic              req;         // held until ready_req_i
		logic              rw;          // 1: write-back, 0: fetch
		logic [BW_TAG-1:0] block_addr;
	} mem_cmd_t;

	// single cycle flags, controller to counters
	typedef struct packed {
		logic request;
		logic hit;
		logic miss;
		logic writeback;
	} event_t;

	// counter read-out select
	typedef enum logic [1:0] {
		METRIC_REQUESTS   = 2'd0,
		METRIC_HITS       = 2'd1,
		METRIC_MISSES     = 2'd2,
		METRIC_WRITEBACKS = 2'd3
	} metric_sel_e;

endpackage

//--- source/fa_cache_top.sv
`timescale 1ns/1ns

module fa_cache_top #(
	parameter int CACHE_BLOCK_CAPACITY = 8           // blocks, power of two
)(
	input  logic                                    clock_bus_i,
	input  logic                                    resetn_i,

	// core side
	input  logic                                    req_i,
	input  logic                                    rw_i,           // 1: write
	input  logic [fa_cache_pkg::BW_WORD_ADDR-1:0]   add_i,
	input  logic [fa_cache_pkg::BW_DATA-1:0]        data_i,
	input  fa_cache_pkg::metric_sel_e               metric_sel_i,
	output logic                                    ready_o,
	output logic                                    done_o,
	output logic                                    hit_o,
	output logic [fa_cache_pkg::BW_DATA-1:0]        data_o,
	output logic [31:0]                             count_o,

	// memory side
	input  logic                                    ready_req_i,
	input  logic                                    ready_read_i,
	input  logic                                    ready_write_i,
	input  logic [fa_cache_pkg::BW_DATA-1:0]        mem_data_i,
	output fa_cache_pkg::mem_cmd_t                  mem_cmd_o,
	output logic                                    read_o,
	output logic                                    write_o,
	output logic [fa_cache_pkg::BW_DATA-1:0]        mem_data_o
);

	localparam int BW_WAY = $clog2(CACHE_BLOCK_CAPACITY);

	// internal nets
	// ------------------------------
	fa_cache_pkg::core_req_t                        core_req;
	fa_cache_pkg::lookup_t                          lookup;
	fa_cache_pkg::event_t                           events;
	logic                                           accept;
	logic                                           cam_hit;
	logic                                           cam_wren;
	logic [BW_WAY-1:0]                              cam_way;
	logic [BW_WAY-1:0]                              cam_way_wr;
	logic [BW_WAY+fa_cache_pkg::BW_BLOCK-1:0]       mem_addr;   // [way|word]
	logic                                           mem_wren;
	logic [fa_cache_pkg::BW_DATA-1:0]               mem_wdata;
	logic [fa_cache_pkg::BW_DATA-1:0]               mem_q;

	// split the word address into tag and offset
	assign core_req.rw    = rw_i;
	assign core_req.tag   = add_i[fa_cache_pkg::BW_WORD_ADDR-1:fa_cache_pkg::BW_BLOCK];
	assign core_req.word  = add_i[fa_cache_pkg::BW_BLOCK-1:0];
	assign core_req.wdata = data_i;

	assign data_o = mem_q;        // read data, valid with done_o

	// stages
	// ------------------------------
	fa_tag_lookup #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) lookup0 (
		.clock_bus_i  (clock_bus_i),
		.resetn_i     (resetn_i),
		.req_i        (req_i),
		.req_data_i   (core_req),
		.accept_i     (accept),
		.cam_wren_i   (cam_wren),
		.cam_way_wr_i (cam_way_wr),
		.lookup_o     (lookup),
		.ready_o      (ready_o),
		.cam_hit_o    (cam_hit),
		.cam_way_o    (cam_way)
	);

	fa_cache_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) ctrl0 (
		.clock_bus_i   (clock_bus_i),
		.resetn_i      (resetn_i),
		.lookup_i      (lookup),
		.cam_hit_i     (cam_hit),
		.cam_way_i     (cam_way),
		.accept_o      (accept),
		.cam_wren_o    (cam_wren),
		.cam_way_wr_o  (cam_way_wr),
		.mem_q_i       (mem_q),
		.mem_addr_o    (mem_addr),
		.mem_wren_o    (mem_wren),
		.mem_wdata_o   (mem_wdata),
		.done_o        (done_o),
		.hit_o         (hit_o),
		.events_o      (events),
		.ready_req_i   (ready_req_i),
		.ready_read_i  (ready_read_i),
		.ready_write_i (ready_write_i),
		.mem_data_i    (mem_data_i),
		.mem_cmd_o     (mem_cmd_o),
		.read_o        (read_o),
		.write_o       (write_o),
		.mem_data_o    (mem_data_o)
	);

	fa_block_memory #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) bmem0 (
		.clock_bus_i (clock_bus_i),
		.addr_i      (mem_addr),
		.wren_i      (mem_wren),
		.wdata_i     (mem_wdata),
		.q_o         (mem_q)
	);

	fa_perf_counters perf0 (
		.clock_bus_i  (clock_bus_i),
		.resetn_i     (resetn_i),
		.events_i     (events),
		.metric_sel_i (metric_sel_i),
		.count_o      (count_o)
	);

endmodule

//--- source/fa_perf_counters.sv
`timescale 1ns/1ns

module fa_perf_counters (
	input  logic                      clock_bus_i,
	input  logic                      resetn_i,
	input  fa_cache_pkg::event_t      events_i,
	input  fa_cache_pkg::metric_sel_e metric_sel_i,
	output logic [31:0]               count_o
);

	logic [31:0] cnt_q [4];      // indexed like metric_sel_e
	logic [3:0]  inc;

	// flag order follows the enum encoding
	assign inc = {events_i.writeback, events_i.miss, events_i.hit, events_i.request};

	// saturating counters
	// ------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			cnt_q <= '{default: '0};
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (inc[i] && (cnt_q[i] != '1)) begin
					cnt_q[i] <= cnt_q[i] + 1'b1;   // sticks at all ones
				end
			end
		end
	end

	// read-out mux
	// ------------------------------
	always_comb begin
		case (metric_sel_i)
			fa_cache_pkg::METRIC_REQUESTS:   count_o = cnt_q[0];
			fa_cache_pkg::METRIC_HITS:       count_o = cnt_q[1];
			fa_cache_pkg::METRIC_MISSES:     count_o = cnt_q[2];
			fa_cache_pkg::METRIC_WRITEBACKS: count_o = cnt_q[3];
			default:                         count_o = '0;
		endcase
	end

endmodule

//--- source/fa_tag_lookup.sv
`timescale 1ns/1ns

module fa_tag_lookup #(
	parameter int CACHE_BLOCK_CAPACITY = 8
)(
	input  logic                                    clock_bus_i,
	input  logic                                    resetn_i,
	input  logic                                    req_i,          // one cycle core pulse
	input  fa_cache_pkg::core_req_t                 req_data_i,
	input  logic                                    accept_i,       // controller takes held request
	input  logic                                    cam_wren_i,     // fill: install held tag
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_way_wr_i,
	output fa_cache_pkg::lookup_t                   lookup_o,
	output logic                                    ready_o,
	output logic                                    cam_hit_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_way_o
);

	localparam int BW_WAY = $clog2(CACHE_BLOCK_CAPACITY);

	// request register
	// ------------------------------
	logic                    lk_valid;
	fa_cache_pkg::core_req_t lk_req;

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			lk_valid <= 1'b0;
		end else if (accept_i) begin
			lk_valid <= req_i;            // drops to 0 when the core is quiet
		end
	end

	// payload follows valid, held while accept is low
	always_ff @(posedge clock_bus_i) begin
		if (accept_i) begin
			lk_req <= req_data_i;
		end
	end

	assign lookup_o.valid = lk_valid;
	assign lookup_o.req   = lk_req;

	// a held request stalls the core
	assign ready_o = !(lk_valid && !accept_i);

	// tag CAM
	// ------------------------------
	logic [fa_cache_pkg::BW_TAG-1:0] tag_mem [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q;     // one bit per way
	logic [CACHE_BLOCK_CAPACITY-1:0] match;

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (cam_wren_i) begin
			valid_q[cam_way_wr_i] <= 1'b1;    // ways are never invalidated
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (cam_wren_i) begin
			tag_mem[cam_way_wr_i] <= lk_req.tag;  // the missing tag is still held
		end
	end

	// parallel compare against every valid way
	always_comb begin
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			match[i] = valid_q[i] && (tag_mem[i] == lk_req.tag);
		end
	end

	// one-hot to binary, at most one way matches
	always_comb begin
		cam_way_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (match[i]) begin
				cam_way_o = cam_way_o | BW_WAY'(i);
			end
		end
	end

	assign cam_hit_o = |match;

endmodule
